/* Bender.yml */
package:
  name: soc_mem

sources:
  - src/soc_pkg.sv
  - src/sys_timer.sv
  - src/boot_rom.sv
  - src/byte_ram.sv
  - src/port_block.sv
  - src/mem_bus.sv
  - src/soc_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_soc.sv

/* files.f */
src/soc_pkg.sv
src/sys_timer.sv
src/boot_rom.sv
src/byte_ram.sv
src/port_block.sv
src/mem_bus.sv
src/soc_top.sv
tests/tb_clock.sv
tests/tb_soc.sv

/* src/boot_rom.sv */
`default_nettype none

module boot_rom (
    input  logic                        clk,
    input  logic                        rd,
    input  logic [soc_pkg::ROM_BITS-1:0] addr,
    output soc_pkg::word_t              rdata
);
    import soc_pkg::*;

    localparam int ROM_WORDS = 1 << ROM_BITS;

    word_t rom [0:ROM_WORDS-1];

    // boot image, one 32-bit word per line
    initial begin
        $readmemh("tests/rom_image.hex", rom);
    end

    // data holds until the next read of this rom
    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= rom[addr];
        end
    end

endmodule

`default_nettype wire

/* src/byte_ram.sv */
`default_nettype none

module byte_ram (
    input  logic                         clk,
    input  logic                         rd,
    input  soc_pkg::byte_en_t            we,
    input  logic [soc_pkg::RAM_BITS-1:0] addr,
    input  soc_pkg::word_t               wdata,
    output soc_pkg::word_t               rdata
);
    import soc_pkg::*;

    localparam int RAM_WORDS = 1 << RAM_BITS;
    localparam int LANES     = 4;

    logic [7:0] byte_q [LANES];  // read data per lane

    // ============================================================
    // byte lanes
    // ============================================================

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        logic [7:0] lane_mem [0:RAM_WORDS-1];

        always_ff @(posedge clk) begin
            if (we[i]) begin
                lane_mem[addr] <= wdata[8*i +: 8];
            end
        end

        always_ff @(posedge clk) begin
            if (rd) begin
                byte_q[i] <= lane_mem[addr];
            end
        end
    end

    // lane 0 is the low byte
    assign rdata = {byte_q[3], byte_q[2], byte_q[1], byte_q[0]};

endmodule

`default_nettype wire

/* src/mem_bus.sv */
`default_nettype none

module mem_bus (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::bus_req_t bus_req,
    output soc_pkg::word_t    rdata,
    input  soc_pkg::port_in_t pins,
    output logic              led,
    inout  wire               scl_io,
    inout  wire               sda_io
);
    import soc_pkg::*;

    region_t region;
    region_t rd_region;  // region of the last read

    logic [ROM_BITS-1:0] rom_addr;
    logic [RAM_BITS-1:0] ram_addr;

    logic     rom_rd;
    logic     ram_rd;
    byte_en_t ram_we;
    logic     port_rd;
    logic     port_we0;

    word_t rom_rdata;
    word_t ram_rdata;
    word_t port_rdata;

    // ============================================================
    // decode and strobe steering
    // ============================================================

    assign region   = bus_req.addr[31:30];
    assign rom_addr = bus_req.addr[ROM_BITS+1:2];  // word address
    assign ram_addr = bus_req.addr[RAM_BITS+1:2];

    assign rom_rd   = bus_req.rd && (region == REGION_ROM);
    assign ram_rd   = bus_req.rd && (region == REGION_RAM);
    assign ram_we   = (region == REGION_RAM) ? bus_req.we : '0;
    assign port_rd  = bus_req.rd && (region == REGION_PORTS);
    assign port_we0 = bus_req.we[0] && (region == REGION_PORTS);

    boot_rom u_rom (
        .clk   (clk),
        .rd    (rom_rd),
        .addr  (rom_addr),
        .rdata (rom_rdata)
    );

    byte_ram u_ram (
        .clk   (clk),
        .rd    (ram_rd),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (bus_req.wdata),
        .rdata (ram_rdata)
    );

    port_block u_ports (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd     (port_rd),
        .we0    (port_we0),
        .wdata  (bus_req.wdata),
        .pins   (pins),
        .rdata  (port_rdata),
        .led    (led),
        .scl_io (scl_io),
        .sda_io (sda_io)
    );

    // ============================================================
    // read return
    // ============================================================

    // unmapped region out of reset, so rdata starts at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_region <= REGION_NONE;
        end else if (bus_req.rd) begin
            rd_region <= region;
        end
    end

    always_comb begin
        case (rd_region)
            REGION_ROM:   rdata = rom_rdata;
            REGION_RAM:   rdata = ram_rdata;
            REGION_PORTS: rdata = port_rdata;
            REGION_NONE:  rdata = '0;
            default:      rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/port_block.sv */
`default_nettype none

module port_block (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rd,
    input  logic               we0,
    input  soc_pkg::word_t     wdata,
    input  soc_pkg::port_in_t  pins,
    output soc_pkg::word_t     rdata,
    output logic               led,
    inout  wire                scl_io,
    inout  wire                sda_io
);

    logic scl_q;  // 0 pulls the line low
    logic sda_q;

    // ============================================================
    // output registers
    // ============================================================

    // lines released and led set out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led   <= 1'b1;
            scl_q <= 1'b1;
            sda_q <= 1'b1;
        end else if (we0) begin
            {led, scl_q, sda_q} <= wdata[2:0];
        end
    end

    // open drain, the pullup gives the high level
    assign scl_io = scl_q ? 1'bz : 1'b0;
    assign sda_io = sda_q ? 1'bz : 1'b0;

    // ============================================================
    // input port
    // ============================================================

    // bus levels are sampled, so another master pulling low shows up
    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= {25'b0,
                      pins.con_button,
                      pins.psh_button,
                      pins.tra,
                      pins.trb,
                      pins.bak_button,
                      scl_io,
                      sda_io};
        end
    end

endmodule

`default_nettype wire

/* src/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // ============================================================
    // basic types
    // ============================================================

    typedef logic [31:0] word_t;     // data and byte address
    typedef logic [3:0]  byte_en_t;  // one write enable per byte lane
    typedef logic [1:0]  region_t;   // address bits 31:30

    // ============================================================
    // address map
    // ============================================================

    localparam region_t REGION_ROM   = 2'd0;
    localparam region_t REGION_RAM   = 2'd1;
    localparam region_t REGION_NONE  = 2'd2;  // nothing mapped here
    localparam region_t REGION_PORTS = 2'd3;

    // memory sizes as word-address widths
    localparam int RAM_BITS = 10;  // 1k words
    localparam int ROM_BITS = 10;  // 1k words

    // ============================================================
    // system timer
    // ============================================================

    localparam int TIMER_BITS      = 10;  // irq every 1024 cycles
    localparam int RESET_DELAY_BIT = 6;   // cpu leaves reset after 64 counts
    localparam int CPU_CLOCK_BIT   = 2;   // clock enable every 8 cycles

    // ============================================================
    // bus and pin bundles
    // ============================================================

    // one request per cycle, rd and we never together
    typedef struct packed {
        word_t    addr;
        word_t    wdata;
        logic     rd;
        byte_en_t we;
    } bus_req_t;

    // order matches the port read layout, bits 6 down to 2
    typedef struct packed {
        logic con_button;
        logic psh_button;
        logic tra;         // encoder phase a
        logic trb;         // encoder phase b
        logic bak_button;
    } port_in_t;

endpackage

`default_nettype wire

/* src/soc_top.sv */
`default_nettype none

module soc_top (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::bus_req_t bus_req,
    output soc_pkg::word_t    rdata,
    input  logic              irq_ack,
    output logic              cpu_clk_en,
    output logic              cpu_rst_n,
    output logic              timer_irq,
    input  logic              con_button,
    input  logic              psh_button,
    input  logic              tra,
    input  logic              trb,
    input  logic              bak_button,
    output logic              led,
    inout  wire               scl_io,
    inout  wire               sda_io
);
    import soc_pkg::*;

    port_in_t pins_in;  // loose pins bundled for the port block

    assign pins_in = '{con_button: con_button,
                       psh_button: psh_button,
                       tra:        tra,
                       trb:        trb,
                       bak_button: bak_button};

    mem_bus u_bus (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .rdata   (rdata),
        .pins    (pins_in),
        .led     (led),
        .scl_io  (scl_io),
        .sda_io  (sda_io)
    );

    sys_timer u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .irq_ack    (irq_ack),
        .cpu_clk_en (cpu_clk_en),
        .cpu_rst_n  (cpu_rst_n),
        .timer_irq  (timer_irq)
    );

endmodule

`default_nettype wire

/* src/sys_timer.sv */
`default_nettype none

module sys_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic irq_ack,
    output logic cpu_clk_en,
    output logic cpu_rst_n,
    output logic timer_irq
);
    import soc_pkg::*;

    logic [TIMER_BITS-1:0] count;
    logic                  count_wrap;

    // ============================================================
    // free-running counter
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign count_wrap = &count;  // last value before rolling over

    // one cycle wide, on counts 7, 15, 23, ...
    assign cpu_clk_en = &count[CPU_CLOCK_BIT:0];

    // ============================================================
    // cpu reset delay
    // ============================================================

    // sticky once released, the counter bit toggles later on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpu_rst_n <= 1'b0;
        end else if (count[RESET_DELAY_BIT]) begin
            cpu_rst_n <= 1'b1;
        end
    end

    // ============================================================
    // timer interrupt
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_irq <= 1'b0;
        end else if (irq_ack) begin
            timer_irq <= 1'b0;  // ack beats a wrap in the same cycle
        end else if (count_wrap) begin
            timer_irq <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tests/rom_image.hex */
// boot image for region 0, one 32-bit word per line
// first line is word address 0
00000093
00100113
002081b3
40000237
00322023
00022283
c0000337
00532023
00430313
0000006f
deadbeef
0badf00d
13579bdf
2468ace0
a5a5a5a5
5a5a5a5a

/* tests/soc_tests.mem */
// op addr data byte_en expected, all hex, one vector per line
// op 0 read, 1 write, 2 set pins, 3 irq ack, 4 random ram write, 5 wait irq,
// 6 check led/scl/sda, f end; ram reads take the expected value from the lane model
0 00000000 00000000 0 00000093
0 00000004 00000000 0 00100113
0 00000014 00000000 0 00022283
0 0000003c 00000000 0 5a5a5a5a
1 40000000 11223344 f 00000000
0 40000000 00000000 0 00000000
4 40000000 00000000 0 00000000
0 40000000 00000000 0 00000000
1 40000ffc 01020304 f 00000000
4 40000ffc 00000000 0 00000000
4 40000ffc 00000000 0 00000000
0 40000ffc 00000000 0 00000000
1 40000000 a5a5a5a5 6 00000000
0 40000000 00000000 0 00000000
6 00000000 00000000 0 00000007
2 00000000 00000016 0 00000000
0 c0000000 00000000 0 0000005b
1 c0000000 00000004 1 00000000
6 00000000 00000000 0 00000004
0 c0000000 00000000 0 00000058
2 00000000 00000009 0 00000000
0 c0000000 00000000 0 00000024
1 c0000000 00000007 1 00000000
6 00000000 00000000 0 00000007
0 c0000000 00000000 0 00000027
0 80000000 00000000 0 00000000
1 80000000 00000000 f 00000000
0 40000000 00000000 0 00000000
0 c0000000 00000000 0 00000027
6 00000000 00000000 0 00000007
0 bffffffc 00000000 0 00000000
5 00000000 00000000 0 00000400
3 00000000 00000000 0 00000000
f 00000000 00000000 0 00000000

/* tests/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // period 10
    end

    // release on a falling edge, clear of the rising edges
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tests/tb_soc.sv */
`default_nettype none

module tb_soc;
    import soc_pkg::*;

    localparam int MAX_VECTORS    = 64;
    localparam int FIELDS         = 5;     // op, addr, data, byte_en, expected
    localparam int RESET_TIMEOUT  = 100;
    localparam int IRQ_TIMEOUT    = 2000;
    localparam int MONITOR_CYCLES = 256;

    logic     clk;
    logic     rst_n;
    bus_req_t bus_req;
    word_t    rdata;
    port_in_t pins;
    logic     irq_ack;
    logic     cpu_clk_en;
    logic     cpu_rst_n;
    logic     timer_irq;
    logic     led;
    wire      scl_io;
    wire      sda_io;

    word_t      vectors [0:MAX_VECTORS*FIELDS-1];
    logic [7:0] ram_model [4][1 << RAM_BITS];  // one array per byte lane

    integer seed         = 32'h26d0f86d;
    int     error_count  = 0;
    int     check_count  = 0;
    int     edge_count   = 0;
    logic   timed_out    = 1'b0;
    logic   monitor_done = 1'b0;

    pullup (scl_io);
    pullup (sda_io);

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    soc_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_req    (bus_req),
        .rdata      (rdata),
        .irq_ack    (irq_ack),
        .cpu_clk_en (cpu_clk_en),
        .cpu_rst_n  (cpu_rst_n),
        .timer_irq  (timer_irq),
        .con_button (pins.con_button),
        .psh_button (pins.psh_button),
        .tra        (pins.tra),
        .trb        (pins.trb),
        .bak_button (pins.bak_button),
        .led        (led),
        .scl_io     (scl_io),
        .sda_io     (sda_io)
    );

    // rising edges since reset release
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_count <= 0;
        end else begin
            edge_count <= edge_count + 1;
        end
    end

    // ============================================================
    // checks and helpers
    // ============================================================

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < RESET_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            timed_out = 1'b1;
            $display("ERROR: reset was never released");
        end
    endtask

    // drives one strobe cycle and returns on the falling edge where read data is valid
    task automatic bus_access(input word_t addr, input word_t wdata, input logic rd,
                              input byte_en_t we);
        @(negedge clk);
        bus_req = '{addr: addr, wdata: wdata, rd: rd, we: we};
        @(negedge clk);
        bus_req = '0;
    endtask

    function automatic word_t model_read(input word_t addr);
        logic [RAM_BITS-1:0] wa;
        wa = addr[RAM_BITS+1:2];
        return {ram_model[3][wa], ram_model[2][wa], ram_model[1][wa], ram_model[0][wa]};
    endfunction

    task automatic model_write(input word_t addr, input word_t data, input byte_en_t we);
        logic [RAM_BITS-1:0] wa;
        wa = addr[RAM_BITS+1:2];
        if (addr[31:30] == REGION_RAM) begin  // other regions leave ram alone
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    ram_model[i][wa] = data[8*i +: 8];
                end
            end
        end
    endtask

    // ============================================================
    // timer monitor
    // ============================================================

    initial begin
        int n;
        wait_reset_release();
        n = 0;
        while (n < MONITOR_CYCLES && !timed_out) begin
            @(negedge clk);
            n++;
            check_bit($sformatf("cpu_rst_n edge %0d", edge_count), edge_count >= 65, cpu_rst_n);
            check_bit($sformatf("cpu_clk_en edge %0d", edge_count), (edge_count % 8) == 7,
                      cpu_clk_en);
        end
        monitor_done = 1'b1;
    end

    // ============================================================
    // vector sequence
    // ============================================================

    initial begin
        word_t    op;
        word_t    addr;
        word_t    data;
        word_t    exp;
        byte_en_t be;
        string    name;
        logic     done;
        int       n;

        bus_req = '0;
        pins    = '0;
        irq_ack = 1'b0;
        $readmemh("tests/soc_tests.mem", vectors);
        wait_reset_release();
        done = 1'b0;

        // no read yet, so the return path still shows the reset state
        if (!timed_out) begin
            check_word("rdata after reset", '0, rdata);
            check_bit("timer_irq after reset", 1'b0, timer_irq);
        end

        for (int i = 0; i < MAX_VECTORS && !done && !timed_out; i++) begin
            op   = vectors[i*FIELDS];
            addr = vectors[i*FIELDS+1];
            data = vectors[i*FIELDS+2];
            be   = byte_en_t'(vectors[i*FIELDS+3]);
            exp  = vectors[i*FIELDS+4];
            name = $sformatf("vector %0d", i);
            case (op)
                0: begin
                    bus_access(addr, '0, 1'b1, '0);
                    if (addr[31:30] == REGION_RAM) begin
                        exp = model_read(addr);
                    end
                    check_word({name, " read"}, exp, rdata);
                end
                1: begin
                    bus_access(addr, data, 1'b0, be);
                    model_write(addr, data, be);
                end
                2: begin
                    @(negedge clk);
                    pins = port_in_t'(data[4:0]);
                end
                3: begin
                    @(negedge clk);
                    check_bit({name, " irq held"}, 1'b1, timer_irq);
                    irq_ack = 1'b1;
                    @(negedge clk);
                    irq_ack = 1'b0;
                    check_bit({name, " irq cleared"}, exp[0], timer_irq);
                end
                4: begin
                    be   = byte_en_t'($random(seed));
                    data = $random(seed);
                    bus_access(addr, data, 1'b0, be);
                    model_write(addr, data, be);
                end
                5: begin
                    n = 0;
                    while (timer_irq !== 1'b1 && n < IRQ_TIMEOUT) begin
                        @(negedge clk);
                        n++;
                    end
                    if (timer_irq !== 1'b1) begin
                        timed_out = 1'b1;
                        $display("ERROR: timer interrupt never rose");
                    end else begin
                        check_word({name, " irq edge"}, exp, word_t'(edge_count));
                    end
                end
                6: begin
                    check_bit({name, " led"}, exp[2], led);
                    check_bit({name, " scl"}, exp[1], scl_io);
                    check_bit({name, " sda"}, exp[0], sda_io);
                end
                32'hf: done = 1'b1;
                default: begin
                    error_count++;
                    $display("ERROR: vector %0d has an unknown opcode %h", i, op);
                    done = 1'b1;
                end
            endcase
        end

        n = 0;
        while (!monitor_done && !timed_out && n < IRQ_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!monitor_done && !timed_out) begin
            timed_out = 1'b1;
            $display("ERROR: timer monitor did not finish");
        end

        $display("%0d checks, %0d errors, timeout %0d", check_count, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
